// File: calc.f
+incdir+test
src/calc_pkg.sv
src/digit_entry.sv
src/add_sub_unit.sv
src/shift_add_multiplier.sv
src/calc_controller.sv
src/calc_top.sv
test/calc_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = calc_tb
FILELIST  = calc.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: test/calc_tb_pkg.svh
`ifndef CALC_TB_PKG_SVH
`define CALC_TB_PKG_SVH

localparam int SEED_INIT = 43;      // Random operand cases

// One calculation, keys hold one digit per nibble, top nibble keyed first
typedef struct packed {
    logic [3:0]  a_len;     // Digits in first operand
    logic [31:0] a_keys;
    op_onehot_t  op;        // Operator key code
    logic [3:0]  b_len;     // Digits in second operand
    logic [31:0] b_keys;
    operand_t    expected;  // Display value after equal
} calc_case_t;

calc_case_t case_table[$];  // Stimulus table

// Each digit makes the operand x*10 + d, kept mod 2^16
function automatic operand_t keyed_value(input logic [3:0] len, input logic [31:0] keys);
    int unsigned acc;
    int          i;
    acc = 0;
    for (i = int'(len) - 1; i >= 0; i--) begin
        acc = (acc * 10 + 32'(keys[i*4 +: 4])) % 65536;
    end
    return operand_t'(acc);
endfunction

// Reference arithmetic, unsigned mod 2^16
function automatic operand_t expected_result(input operand_t a, input op_onehot_t op,
                                             input operand_t b);
    longint unsigned r;
    case (op)
        3'b001:  r = longint'(a) + longint'(b);             // Add
        3'b010:  r = 65536 + longint'(a) - longint'(b);     // Sub, wraps below zero
        3'b100:  r = longint'(a) * longint'(b);             // Mul, low 16 bits kept
        default: r = 0;
    endcase
    return operand_t'(r % 65536);
endfunction

function automatic calc_case_t make_case(input logic [3:0] a_len, input logic [31:0] a_keys,
                                         input op_onehot_t op,
                                         input logic [3:0] b_len, input logic [31:0] b_keys);
    calc_case_t c;
    c.a_len    = a_len;
    c.a_keys   = a_keys;
    c.op       = op;
    c.b_len    = b_len;
    c.b_keys   = b_keys;
    c.expected = expected_result(keyed_value(a_len, a_keys), op, keyed_value(b_len, b_keys));
    return c;
endfunction

task automatic fill_table();
    case_table.push_back(make_case(4'd3, 32'h123, KEY_ADD, 4'd3, 32'h456));         // 0
    case_table.push_back(make_case(4'd4, 32'h1005, KEY_ADD, 4'd4, 32'h2090));       // 1 Zeros
    case_table.push_back(make_case(4'd1, 32'h0, KEY_ADD, 4'd1, 32'h0));             // 2
    case_table.push_back(make_case(4'd5, 32'h65535, KEY_ADD, 4'd1, 32'h1));         // 3 Carry out
    case_table.push_back(make_case(4'd3, 32'h500, KEY_SUB, 4'd3, 32'h123));         // 4
    case_table.push_back(make_case(4'd2, 32'h12, KEY_SUB, 4'd3, 32'h345));          // 5 Wraps
    case_table.push_back(make_case(4'd1, 32'h0, KEY_SUB, 4'd1, 32'h1));             // 6 All ones
    case_table.push_back(make_case(4'd3, 32'h007, KEY_SUB, 4'd1, 32'h7));           // 7 Leading zeros
    case_table.push_back(make_case(4'd2, 32'h12, KEY_MUL, 4'd2, 32'h34));           // 8
    case_table.push_back(make_case(4'd3, 32'h300, KEY_MUL, 4'd3, 32'h300));         // 9 Overflow
    case_table.push_back(make_case(4'd1, 32'h0, KEY_MUL, 4'd4, 32'h9999));          // 10 Zero
    case_table.push_back(make_case(4'd5, 32'h65535, KEY_MUL, 4'd5, 32'h65535));     // 11
    case_table.push_back(make_case(4'd3, 32'h256, KEY_MUL, 4'd3, 32'h256));         // 12 Exactly 2^16
    case_table.push_back(make_case(4'd7, 32'h1234567, KEY_ADD, 4'd1, 32'h1));       // 13 Long a
    case_table.push_back(make_case(4'd5, 32'h99999, KEY_MUL, 4'd1, 32'h3));         // 14
    case_table.push_back(make_case(4'd8, 32'h98765432, KEY_SUB, 4'd6, 32'h123456)); // 15
    case_table.push_back(make_case(4'd2, 32'h10, KEY_MUL, 4'd6, 32'h100000));       // 16 Long b
endtask

`endif

// File: test/calc_tb.sv
`default_nettype none
`timescale 1ns/10ps

module calc_tb import calc_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 100;    // Per wait for complete
    localparam int RANDOM_CASES   = 24;

    logic       clk;
    logic       nRST;
    logic       key_strobe;
    digit_t     key_digit;
    op_onehot_t operator_input;
    logic       equal_input;
    logic       complete;
    operand_t   display_output;
    logic       busy;

    int       seed;
    int       error_count;
    operand_t shown;            // Value the display must hold

    `include "calc_tb_pkg.svh"

    calc_top UUT (
        .clk(clk), .nRST(nRST),
        .key_strobe(key_strobe), .key_digit(key_digit),
        .operator_input(operator_input), .equal_input(equal_input),
        .complete(complete), .display_output(display_output), .busy(busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;     // 100 ns period
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input operand_t got, input operand_t exp);
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %0t: %s, got %0d expected %0d", $time, what, got, exp);
            abort_run("Stopped at the first mismatch");
        end
    endtask

    // Edge, then 5 ns settle; inputs change right after this returns
    task automatic next_cycle();
        @(posedge clk);
        #5;
        if (!complete) begin
            check_value("display hold", display_output, shown);   // Only moves with complete
        end
    endtask

    function automatic int unsigned next_random();
        return $unsigned($random(seed));
    endfunction

    task automatic press_digit(input digit_t d);
        key_strobe = 1'b1;
        key_digit  = d;
        next_cycle();
        key_strobe = 1'b0;
        key_digit  = '0;
    endtask

    task automatic select_operator(input op_onehot_t code);
        operator_input = code;      // Level for one cycle
        next_cycle();
        operator_input = '0;
    endtask

    task automatic pulse_equal();
        equal_input = 1'b1;
        next_cycle();
        equal_input = 1'b0;
    endtask

    function automatic logic [31:0] random_keys(input logic [3:0] len);
        logic [31:0] keys;
        int          i;
        keys = '0;
        for (i = 0; i < int'(len); i++) begin
            keys[i*4 +: 4] = 4'(next_random() % 10);
        end
        return keys;
    endfunction

    function automatic calc_case_t random_case();
        logic [3:0] a_len;
        logic [3:0] b_len;
        op_onehot_t op;
        a_len = 4'(1 + next_random() % 6);     // Up to six digits, wraps past five
        b_len = 4'(1 + next_random() % 6);
        case (next_random() % 3)
            0:       op = KEY_ADD;
            1:       op = KEY_SUB;
            default: op = KEY_MUL;
        endcase
        return make_case(a_len, random_keys(a_len), op, b_len, random_keys(b_len));
    endfunction

    // One full calculation, optionally with inputs the DUT must ignore
    task automatic run_calc(input calc_case_t c, input logic early_equal,
                            input logic bad_ops, input logic busy_keys);
        int i;
        int cycles;
        int burst;
        for (i = int'(c.a_len) - 1; i >= 0; i--) begin
            press_digit(c.a_keys[i*4 +: 4]);
        end
        if (early_equal) begin
            pulse_equal();                  // No operator yet
        end
        if (bad_ops) begin
            select_operator(3'b011);        // Not one-hot
            select_operator(3'b110);
            select_operator(3'b111);
        end
        select_operator(c.op);
        for (i = int'(c.b_len) - 1; i >= 0; i--) begin
            press_digit(c.b_keys[i*4 +: 4]);
        end
        pulse_equal();
        check_value("busy after equal", operand_t'(busy), 16'd1);
        cycles = 0;
        burst  = 0;
        while (!complete) begin
            if (cycles >= TIMEOUT_CYCLES) begin
                abort_run($sformatf("Timeout: no complete within %0d cycles", TIMEOUT_CYCLES));
            end else begin
                if (busy_keys && busy && burst < 3) begin
                    key_strobe  = 1'b1;             // Keys and equal while busy
                    key_digit   = digit_t'(next_random() % 10);
                    equal_input = 1'b1;
                    burst++;
                end
                next_cycle();
                key_strobe  = 1'b0;
                key_digit   = '0;
                equal_input = 1'b0;
                cycles++;
            end
        end
        check_value("result", display_output, c.expected);
        check_value("busy at complete", operand_t'(busy), '0);
        shown = c.expected;
        next_cycle();
        check_value("complete pulse width", operand_t'(complete), '0);
        check_value("operand a cleared", UUT.u_entry.a_value, '0);
        check_value("operand b cleared", UUT.u_entry.b_value, '0);
    endtask

    initial begin
        calc_case_t c;
        int         n;
        seed           = SEED_INIT;
        error_count    = 0;
        shown          = '0;
        nRST           = 1'b1;
        key_strobe     = 1'b0;
        key_digit      = '0;
        operator_input = '0;
        equal_input    = 1'b0;
        fill_table();
        repeat (8) @(posedge clk);      // Reset for 8 cycles
        #5;
        nRST = 1'b0;
        check_value("display after reset", display_output, '0);
        check_value("complete after reset", operand_t'(complete), '0);
        check_value("busy after reset", operand_t'(busy), '0);

        // Table, back to back
        for (n = 0; n < case_table.size(); n++) begin
            run_calc(case_table[n], 1'b0, 1'b0, 1'b0);
        end

        // Same entries with inputs that must be ignored
        run_calc(case_table[4], 1'b1, 1'b0, 1'b0);
        run_calc(case_table[9], 1'b0, 1'b1, 1'b0);
        run_calc(case_table[5], 1'b0, 1'b0, 1'b1);
        run_calc(case_table[11], 1'b0, 1'b0, 1'b1);     // Long multiply wait
        run_calc(case_table[8], 1'b1, 1'b1, 1'b1);

        for (n = 0; n < RANDOM_CASES; n++) begin
            c = random_case();
            run_calc(c, 1'b0, 1'b0, 1'(next_random() % 2));
        end

        if (error_count == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("FAIL: see errors above");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// File: src/calc_top.sv
`default_nettype none
`timescale 1ns/10ps

module calc_top import calc_pkg::*; (
    input  logic       clk,
    input  logic       nRST,
    input  logic       key_strobe,      // One-cycle digit strobe
    input  digit_t     key_digit,
    input  op_onehot_t operator_input,  // Level
    input  logic       equal_input,     // One-cycle pulse
    output logic       complete,
    output operand_t   display_output,
    output logic       busy
);

    logic      entry_sel;
    logic      entry_clear;
    operand_t  a_value;
    operand_t  b_value;
    calc_req_t req;         // Shared by both units
    logic      add_start;
    logic      add_finish;
    operand_t  add_result;
    logic      mul_start;
    logic      mul_finish;
    operand_t  mul_result;

    // Sequencing
    calc_controller u_ctrl (
        .clk(clk), .nRST(nRST),
        .key_strobe(key_strobe), .operator_input(operator_input),
        .equal_input(equal_input),
        .a_value(a_value), .b_value(b_value),
        .add_finish(add_finish), .mul_finish(mul_finish),
        .add_result(add_result), .mul_result(mul_result),
        .entry_sel(entry_sel), .entry_clear(entry_clear), .req(req),
        .add_start(add_start), .mul_start(mul_start),
        .complete(complete), .display_output(display_output), .busy(busy)
    );

    // Operand accumulation
    digit_entry u_entry (
        .clk(clk), .nRST(nRST),
        .key_strobe(key_strobe), .key_digit(key_digit),
        .entry_sel(entry_sel), .entry_clear(entry_clear),
        .a_value(a_value), .b_value(b_value)
    );

    // Add and subtract, 1 cycle
    add_sub_unit u_addsub (
        .clk(clk), .nRST(nRST), .start(add_start), .req(req),
        .result(add_result), .finish(add_finish)
    );

    // Multiply, 16 cycles
    shift_add_multiplier u_mul (
        .clk(clk), .nRST(nRST), .start(mul_start), .req(req),
        .result(mul_result), .finish(mul_finish)
    );

endmodule

`default_nettype wire

// File: src/calc_controller.sv
`default_nettype none
`timescale 1ns/10ps

module calc_controller import calc_pkg::*; (
    input  logic       clk,
    input  logic       nRST,
    input  logic       key_strobe,      // Digit key this cycle
    input  op_onehot_t operator_input,  // Level, sampled in S_GET_FIRST
    input  logic       equal_input,     // One-cycle pulse
    input  operand_t   a_value,         // From digit_entry
    input  operand_t   b_value,
    input  logic       add_finish,
    input  logic       mul_finish,
    input  operand_t   add_result,
    input  operand_t   mul_result,
    output logic       entry_sel,       // 0 = a, 1 = b
    output logic       entry_clear,     // Zero both operands
    output calc_req_t  req,             // To both units
    output logic       add_start,
    output logic       mul_start,
    output logic       complete,        // Pulse in S_SHOW
    output operand_t   display_output,  // Held until next result
    output logic       busy             // S_DISPATCH or S_WAIT
);

    ctrl_state_t state;         // Current FSM state
    ctrl_state_t next_state;
    op_kind_t    op_q;          // Latched operator
    op_kind_t    op_decoded;    // From the raw keys
    logic        op_valid;      // Exactly one operator key
    logic        unit_finish;   // Finish of the unit that was started
    operand_t    unit_result;

    // Operator decode, zero or multi-bit codes are rejected
    always_comb begin
        op_valid   = 1'b1;
        op_decoded = OP_ADD;
        case (operator_input)
            KEY_ADD: op_decoded = OP_ADD;
            KEY_SUB: op_decoded = OP_SUB;
            KEY_MUL: op_decoded = OP_MUL;
            default: op_valid = 1'b0;
        endcase
    end

    // Pick the running unit
    assign unit_finish = (op_q == OP_MUL) ? mul_finish : add_finish;
    assign unit_result = (op_q == OP_MUL) ? mul_result : add_result;

    // Next state
    always_comb begin
        next_state = state;
        case (state)
            S_GET_FIRST: begin
                // A digit in the same cycle goes first; the level is seen next cycle
                if (op_valid && !key_strobe) begin
                    next_state = S_GET_SECOND;
                end
            end
            S_GET_SECOND: begin
                if (equal_input) begin
                    next_state = S_DISPATCH;
                end
            end
            S_DISPATCH: next_state = S_WAIT;       // Start issued here
            S_WAIT: begin
                if (unit_finish) begin
                    next_state = S_SHOW;
                end
            end
            S_SHOW:  next_state = S_GET_FIRST;
            default: next_state = S_GET_FIRST;
        endcase
    end

    // State and operator registers
    always_ff @(posedge clk, posedge nRST) begin
        if (nRST) begin
            state <= S_GET_FIRST;
            op_q  <= OP_ADD;
        end else begin
            state <= next_state;
            if (state == S_GET_FIRST && next_state == S_GET_SECOND) begin
                op_q <= op_decoded;     // Latch on the move to b
            end
        end
    end

    // Display register
    always_ff @(posedge clk, posedge nRST) begin
        if (nRST) begin
            display_output <= '0;
        end else if (state == S_WAIT && unit_finish) begin
            display_output <= unit_result;  // Result only valid with finish
        end
    end

    // Request straight from the operand registers
    assign req = '{a: a_value, b: b_value, op: op_q};

    // Strobes and levels
    assign entry_sel   = (state == S_GET_SECOND);
    assign entry_clear = (state == S_SHOW);     // Takes effect leaving S_SHOW
    assign add_start   = (state == S_DISPATCH) && (op_q != OP_MUL);
    assign mul_start   = (state == S_DISPATCH) && (op_q == OP_MUL);
    assign complete    = (state == S_SHOW);
    assign busy        = (state == S_DISPATCH) || (state == S_WAIT);

    // Only one unit runs per calculation
    a_one_start: assert property (
        @(posedge clk) disable iff (nRST)
        !(add_start && mul_start)
    ) else $error("calc_controller: both units started");

    // A finish outside S_WAIT would be a unit answering out of turn
    a_finish_in_wait: assert property (
        @(posedge clk) disable iff (nRST)
        unit_finish |-> (state == S_WAIT)
    ) else $error("calc_controller: finish outside S_WAIT");

endmodule

`default_nettype wire

// File: src/shift_add_multiplier.sv
`default_nettype none
`timescale 1ns/10ps

module shift_add_multiplier import calc_pkg::*; (
    input  logic      clk,
    input  logic      nRST,
    input  logic      start,    // One-cycle request, only when idle
    input  calc_req_t req,      // a and b sampled with start
    output operand_t  result,   // Low 16 bits of a * b
    output logic      finish    // 16 cycles after start
);

    operand_t   acc;        // Partial product, low 16 bits kept
    operand_t   mcand;      // Multiplicand, shifts left each step
    operand_t   mplier;     // Multiplier, shifts right each step
    logic [3:0] bits_left;  // Multiplier bits still to go
    logic       running;    // Busy with a product

    // Control: bit 0 is taken on the start edge, 15 more edges follow
    always_ff @(posedge clk, posedge nRST) begin
        if (nRST) begin
            running   <= 1'b0;
            bits_left <= '0;
            finish    <= 1'b0;
        end else begin
            finish <= 1'b0;                 // Default low, pulse only
            if (start) begin
                running   <= 1'b1;
                bits_left <= 4'd15;
            end else if (running) begin
                bits_left <= bits_left - 4'd1;
                if (bits_left == 4'd1) begin    // Last bit this edge
                    running <= 1'b0;
                    finish  <= 1'b1;
                end
            end
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        if (start) begin
            acc    <= req.b[0] ? req.a : '0;    // Bit 0 partial product
            mcand  <= req.a << 1;
            mplier <= req.b >> 1;
        end else if (running) begin
            if (mplier[0]) begin
                acc <= acc + mcand;             // Wraps mod 2^16
            end
            mcand  <= mcand << 1;               // High bits fall off
            mplier <= mplier >> 1;
        end
    end

    assign result = acc;

    // No back-pressure here, a second start would corrupt the product
    a_start_idle: assert property (
        @(posedge clk) disable iff (nRST)
        start |-> !running
    ) else $error("shift_add_multiplier: start while busy");

    // Finish exactly 16 cycles after an accepted start
    a_latency: assert property (
        @(posedge clk) disable iff (nRST)
        start |-> ##16 finish
    ) else $error("shift_add_multiplier: finish not 16 cycles after start");

endmodule

`default_nettype wire

// File: src/add_sub_unit.sv
`default_nettype none
`timescale 1ns/10ps

module add_sub_unit import calc_pkg::*; (
    input  logic      clk,
    input  logic      nRST,
    input  logic      start,    // One-cycle request
    input  calc_req_t req,      // Sampled with start
    output operand_t  result,   // Valid while finish is high
    output logic      finish    // One cycle after start
);

    operand_t sum;      // a + b mod 2^16
    operand_t diff;     // a - b, wraps below zero

    assign sum  = req.a + req.b;
    assign diff = req.a - req.b;

    // Finish strobe trails start by one edge
    always_ff @(posedge clk, posedge nRST) begin
        if (nRST) begin
            finish <= 1'b0;
        end else begin
            finish <= start;
        end
    end

    // Result register
    always_ff @(posedge clk) begin
        if (start) begin
            result <= (req.op == OP_SUB) ? diff : sum;
        end
    end

    // Controller waits between requests, so finish is always isolated
    a_finish_single: assert property (
        @(posedge clk) disable iff (nRST)
        finish |=> !finish
    ) else $error("add_sub_unit: finish high two cycles in a row");

    // Multiply requests go to the other unit
    a_no_mul_req: assert property (
        @(posedge clk) disable iff (nRST)
        start |-> (req.op != OP_MUL)
    ) else $error("add_sub_unit: started with a multiply request");

endmodule

`default_nettype wire

// File: src/digit_entry.sv
`default_nettype none
`timescale 1ns/10ps

module digit_entry import calc_pkg::*; (
    input  logic     clk,
    input  logic     nRST,
    input  logic     key_strobe,    // One cycle per key press
    input  digit_t   key_digit,     // Valid with key_strobe
    input  logic     entry_sel,     // 0 selects a, 1 selects b
    input  logic     entry_clear,   // Zero both operands
    output operand_t a_value,
    output operand_t b_value
);

    operand_t cur_value;    // Operand being keyed in
    operand_t times_ten;    // cur_value * 10, wrapped
    operand_t next_value;   // After the new digit

    // Selected operand
    assign cur_value = entry_sel ? b_value : a_value;

    // x*10 = x*8 + x*2 with carries above bit 15 dropped
    assign times_ten  = (cur_value << 3) + (cur_value << 1);
    assign next_value = times_ten + operand_t'(key_digit);   // Digit zero-extended

    // Operand registers
    always_ff @(posedge clk, posedge nRST) begin
        if (nRST) begin
            a_value <= '0;
            b_value <= '0;
        end else if (entry_clear) begin     // Clear wins over a late key
            a_value <= '0;
            b_value <= '0;
        end else if (key_strobe) begin
            if (entry_sel) begin
                b_value <= next_value;
            end else begin
                a_value <= next_value;
            end
        end
    end

    // Keypad only ever sends decimal digits
    a_digit_range: assert property (
        @(posedge clk) disable iff (nRST)
        key_strobe |-> (key_digit <= digit_t'(9))
    ) else $error("digit_entry: key_digit %0d out of range", key_digit);

endmodule

`default_nettype wire

// File: src/calc_pkg.sv
`default_nettype none

package calc_pkg;

    // Value widths
    typedef logic [15:0] operand_t;     // Operand or result, unsigned mod 2^16
    typedef logic [3:0]  digit_t;       // One decimal key, 0 to 9
    typedef logic [2:0]  op_onehot_t;   // Raw operator keys, one-hot

    // Operator key codes as they arrive from the keypad
    localparam op_onehot_t KEY_ADD = 3'b001;   // Bit 0
    localparam op_onehot_t KEY_SUB = 3'b010;   // Bit 1
    localparam op_onehot_t KEY_MUL = 3'b100;   // Bit 2

    // Decoded operator, latched by the controller
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_MUL = 2'd2
    } op_kind_t;

    // Controller FSM
    typedef enum logic [2:0] {
        S_GET_FIRST  = 3'd0,    // Digits go to operand a
        S_GET_SECOND = 3'd1,    // Digits go to operand b
        S_DISPATCH   = 3'd2,    // One start strobe
        S_WAIT       = 3'd3,    // Until the unit finishes
        S_SHOW       = 3'd4     // Complete pulse, then clear
    } ctrl_state_t;

    // Request seen by both arithmetic units, 34 bits
    typedef struct packed {
        operand_t a;            // First operand
        operand_t b;            // Second operand
        op_kind_t op;           // Which operation
    } calc_req_t;

endpackage

`default_nettype wire
